/* mem_sys.f */
+incdir+verification
logic/mem_pkg.sv
logic/mem_bus_if.sv
logic/store_merge.sv
logic/main_mem.sv
logic/mem_ctrl.sv
logic/mem_sys_top.sv
verification/mem_sys_tb.sv

/* Bender.yml */
package:
  name: mem_sys

sources:
  - logic/mem_pkg.sv
  - logic/mem_bus_if.sv
  - logic/store_merge.sv
  - logic/main_mem.sv
  - logic/mem_ctrl.sv
  - logic/mem_sys_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/mem_sys_tb.sv

/* verification/mem_sys_model.svh */
`ifndef MEM_SYS_MODEL_SVH
`define MEM_SYS_MODEL_SVH

// sizes taken from the DUT at the start of the run
int          mem_blocks;
int          n_delay;
int          max_out;

block_t      model_mem [];  // block array, updated at each handshake

// expected responses, in handshake order
block_t      ic_exp_data [$];
int          ic_exp_cycle [$];
block_t      dc_exp_data [$];
int          dc_exp_cycle [$];
cache_sel_t  exp_sel_q [$];    // one entry per read, both ports

int          cycle_count    = 0;
int          data_errors    = 0;
int          latency_errors = 0;
int          sel_errors     = 0;
int          other_errors   = 0;

function automatic int block_index(input addr_t addr);
    return int'((addr >> 3) % mem_blocks);  // 8 bytes per block
endfunction

// expected block after a store, built byte by byte
function automatic block_t ref_merge(input block_t old_block, input word_t wdata,
                                     input addr_t addr, input access_width_t width);
    block_t result;
    int     nbytes;
    int     offset;
    result = old_block;
    offset = int'(addr[2:0]);
    case (width)
        BYTE:    nbytes = 1;
        HALF:    nbytes = 2;
        default: nbytes = 4;
    endcase
    for (int i = 0; i < nbytes; i++) begin
        result[(offset + i) * 8 +: 8] = wdata[i * 8 +: 8];
    end
    return result;
endfunction

task automatic model_clear();
    model_mem = new[mem_blocks];
    foreach (model_mem[i]) begin
        model_mem[i] = '0;
    end
endtask

task automatic model_store(input addr_t addr, input word_t wdata, input access_width_t width);
    model_mem[block_index(addr)] = ref_merge(model_mem[block_index(addr)], wdata, addr, width);
endtask

task automatic record_read(input cache_sel_t port, input addr_t addr);
    exp_sel_q.push_back(port);
    if (port == ICACHE) begin
        ic_exp_data.push_back(model_mem[block_index(addr)]);
        ic_exp_cycle.push_back(cycle_count);
    end else begin
        dc_exp_data.push_back(model_mem[block_index(addr)]);
        dc_exp_cycle.push_back(cycle_count);
    end
endtask

task automatic note_failure(input string msg);
    $display("%0t: %s", $time, msg);
    other_errors++;
endtask

task automatic check_block(input string name, input block_t got, input block_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        data_errors++;
    end
endtask

task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        latency_errors++;
    end
endtask

task automatic check_sel(input string name, input cache_sel_t got, input cache_sel_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        sel_errors++;
    end
endtask

// a response seen at this edge was launched by the previous edge
task automatic take_response(input cache_sel_t port, input block_t data);
    cache_sel_t exp_port;
    if (exp_sel_q.size() == 0) begin
        note_failure($sformatf("response on %s port with no read outstanding", port.name()));
    end else begin
        exp_port = exp_sel_q.pop_front();
        check_sel("resp_cache", port, exp_port);
        if (port == ICACHE && ic_exp_data.size() != 0) begin
            check_block("ic_resp_data", data, ic_exp_data.pop_front());
            check_latency("ic_resp latency", cycle_count - ic_exp_cycle.pop_front() - 1,
                          n_delay + 1);
        end else if (port == DCACHE && dc_exp_data.size() != 0) begin
            check_block("dc_resp_data", data, dc_exp_data.pop_front());
            check_latency("dc_resp latency", cycle_count - dc_exp_cycle.pop_front() - 1,
                          n_delay + 1);
        end else begin
            note_failure($sformatf("response on %s port, but no read from it", port.name()));
        end
    end
endtask

`endif

/* verification/mem_sys_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_sys_tb;
    import mem_pkg::*;

    localparam int SEED       = 9487;
    localparam int RAND_REQS  = 300;
    localparam int MAX_IDLE   = 3;
    localparam int FIXED_REQS = 10 + 5 + 28 + 32 + 30;  // directed tests 1 to 5

    logic          clk;
    logic          init;
    logic          ic_req_valid;
    addr_t         ic_req_addr;
    logic          ic_req_ready;
    logic          ic_resp_valid;
    block_t        ic_resp_data;
    logic          dc_req_valid;
    mem_op_t       dc_req_op;
    addr_t         dc_req_addr;
    word_t         dc_req_wdata;
    access_width_t dc_req_width;
    logic          dc_req_ready;
    logic          dc_resp_valid;
    block_t        dc_resp_data;

    int            tb_outstanding = 0;  // reads accepted, response not yet seen
    int            cycle_limit    = 0;
    logic          alt_check      = 1'b0;
    logic          alt_seen       = 1'b0;
    cache_sel_t    alt_last;

    `include "mem_sys_model.svh"

    mem_sys_top u_mem_sys_top (
        .clk           (clk),
        .init          (init),
        .ic_req_valid  (ic_req_valid),
        .ic_req_addr   (ic_req_addr),
        .ic_req_ready  (ic_req_ready),
        .ic_resp_valid (ic_resp_valid),
        .ic_resp_data  (ic_resp_data),
        .dc_req_valid  (dc_req_valid),
        .dc_req_op     (dc_req_op),
        .dc_req_addr   (dc_req_addr),
        .dc_req_wdata  (dc_req_wdata),
        .dc_req_width  (dc_req_width),
        .dc_req_ready  (dc_req_ready),
        .dc_resp_valid (dc_resp_valid),
        .dc_resp_data  (dc_resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // hold the request until it is taken, release on the next falling edge
    task automatic send_ic(input addr_t addr);
        ic_req_valid = 1'b1;
        ic_req_addr  = addr;
        @(posedge clk);
        while (!ic_req_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        ic_req_valid = 1'b0;
    endtask

    task automatic send_dc(input mem_op_t op, input addr_t addr, input word_t wdata,
                           input access_width_t width);
        dc_req_valid = 1'b1;
        dc_req_op    = op;
        dc_req_addr  = addr;
        dc_req_wdata = wdata;
        dc_req_width = width;
        @(posedge clk);
        while (!dc_req_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        dc_req_valid = 1'b0;
    endtask

    // aligned to the width, spans twice the memory so the index wraps
    function automatic addr_t rand_addr(input access_width_t width);
        addr_t a;
        a = addr_t'($urandom_range(0, 2 * mem_blocks - 1)) << 3;
        case (width)
            BYTE:    a[2:0] = 3'($urandom_range(0, 7));
            HALF:    a[2:0] = 3'($urandom_range(0, 3) * 2);
            default: a[2:0] = 3'($urandom_range(0, 1) * 4);
        endcase
        return a;
    endfunction

    task automatic print_summary();
        $display("errors: data %0d latency %0d routing %0d other %0d",
                 data_errors, latency_errors, sel_errors, other_errors);
    endtask

    // values read here are the ones from before the edge
    always @(posedge clk) begin : compare_outputs
        cache_sel_t grant;
        cycle_count = cycle_count + 1;
        if (!init) begin
            if (ic_resp_valid && dc_resp_valid) begin
                note_failure("both response ports valid in one cycle");
            end
            if (ic_resp_valid) begin
                take_response(ICACHE, ic_resp_data);
            end
            if (dc_resp_valid) begin
                take_response(DCACHE, dc_resp_data);
            end
            if (ic_req_ready && tb_outstanding >= max_out) begin
                note_failure("ic read granted with no credit left");
            end
            if (dc_req_ready && dc_req_op == READ && tb_outstanding >= max_out) begin
                note_failure("dc read granted with no credit left");
            end
            if (ic_req_valid && !dc_req_valid && tb_outstanding < max_out && !ic_req_ready) begin
                note_failure("ic_req_ready low although credit is free");
            end
            if (dc_req_valid && dc_req_op == WRITE && !dc_req_ready &&
                    (!ic_req_valid || tb_outstanding >= max_out)) begin
                note_failure("store held back on the dc port");
            end
            if (ic_req_ready && dc_req_ready) begin
                note_failure("both ports granted in one cycle");
            end
            if (alt_check && ic_req_valid && dc_req_valid && (ic_req_ready || dc_req_ready)) begin
                grant = ic_req_ready ? ICACHE : DCACHE;
                if (alt_seen) begin
                    check_sel("arbiter grant", grant, (alt_last == ICACHE) ? DCACHE : ICACHE);
                end
                alt_last = grant;
                alt_seen = 1'b1;
            end
            if (ic_req_valid && ic_req_ready) begin
                record_read(ICACHE, ic_req_addr);
            end
            if (dc_req_valid && dc_req_ready) begin
                if (dc_req_op == WRITE) begin
                    model_store(dc_req_addr, dc_req_wdata, dc_req_width);
                end else begin
                    record_read(DCACHE, dc_req_addr);
                end
            end
            tb_outstanding = tb_outstanding + int'(ic_req_valid && ic_req_ready)
                + int'(dc_req_valid && dc_req_ready && dc_req_op == READ)
                - int'(ic_resp_valid || dc_resp_valid);
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        print_summary();
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main
        void'($urandom(SEED));
        init         = 1'b1;
        ic_req_valid = 1'b0;
        ic_req_addr  = '0;
        dc_req_valid = 1'b0;
        dc_req_op    = READ;
        dc_req_addr  = '0;
        dc_req_wdata = '0;
        dc_req_width = BYTE;
        mem_blocks   = u_mem_sys_top.MEM_BLOCKS;
        n_delay      = u_mem_sys_top.N_DELAY_CYCLES;
        max_out      = u_mem_sys_top.MAX_OUTSTANDING;
        model_clear();
        cycle_limit = (FIXED_REQS + RAND_REQS) * (n_delay + 2) + RAND_REQS * MAX_IDLE + 200;
        repeat (8) @(posedge clk);
        @(negedge clk);
        init = 1'b0;
        idle(2);

        // fresh memory reads back as zero
        for (int i = 0; i < 8; i++) begin
            send_ic(rand_addr(WORD));
        end
        send_dc(READ, rand_addr(WORD), '0, WORD);
        send_dc(READ, rand_addr(WORD), '0, WORD);

        // word store, then a read on the very next cycle
        send_dc(WRITE, 32'h44, 32'hdead_beef, WORD);
        send_dc(READ, 32'h40, '0, WORD);
        send_ic(32'h40);
        send_dc(WRITE, 32'h48, 32'h1234_5678, WORD);
        send_ic(32'h48);

        // byte lanes over a known pattern, upper wdata bits must not leak
        send_dc(WRITE, 32'h100, 32'h3322_1100, WORD);
        send_dc(WRITE, 32'h104, 32'h7766_5544, WORD);
        for (int off = 0; off < 8; off++) begin
            send_dc(WRITE, 32'h100 + off, 32'hffff_ffa0 + off, BYTE);
            send_ic(32'h100);
        end
        send_dc(WRITE, 32'h108, 32'hbbaa_9988, WORD);
        send_dc(WRITE, 32'h10c, 32'hffee_ddcc, WORD);
        for (int off = 0; off < 8; off += 2) begin
            send_dc(WRITE, 32'h108 + off, 32'habcd_c000 + off, HALF);
            send_dc(READ, 32'h108, '0, WORD);
        end

        // both ports busy every cycle
        alt_seen  = 1'b0;
        alt_check = 1'b1;
        fork
            for (int i = 0; i < 16; i++) begin
                send_ic(32'h100 + i * 8);
            end
            for (int i = 0; i < 16; i++) begin
                send_dc(READ, 32'h40 + i * 8, '0, WORD);
            end
        join
        alt_check = 1'b0;

        // stream of ic reads runs into the credit limit, stores get through
        fork
            for (int i = 0; i < 24; i++) begin
                send_ic(rand_addr(WORD));
            end
            begin
                idle(3);
                for (int i = 0; i < 6; i++) begin
                    send_dc(WRITE, rand_addr(WORD), $urandom(), WORD);
                    idle(2);
                end
            end
        join

        // random mix on both ports
        fork
            for (int n = 0; n < RAND_REQS / 3; n++) begin
                idle($urandom_range(0, MAX_IDLE));
                send_ic(rand_addr(BYTE));
            end
            begin : rand_dc
                mem_op_t       op;
                access_width_t wd;
                for (int n = 0; n < RAND_REQS - RAND_REQS / 3; n++) begin
                    idle($urandom_range(0, MAX_IDLE));
                    op = mem_op_t'($urandom_range(0, 1));
                    wd = access_width_t'($urandom_range(0, 2));
                    send_dc(op, rand_addr(wd), $urandom(), wd);
                end
            end
        join

        wait (tb_outstanding == 0);
        idle(4);
        if (ic_exp_data.size() != 0 || dc_exp_data.size() != 0) begin
            note_failure($sformatf("%0d ic and %0d dc responses never arrived",
                                   ic_exp_data.size(), dc_exp_data.size()));
        end
        print_summary();
        if (data_errors + latency_errors + sel_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/mem_sys_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_sys_top #(
    parameter int unsigned MEM_BLOCKS      = 64,
    parameter int unsigned N_DELAY_CYCLES  = 5,
    parameter int unsigned MAX_OUTSTANDING = 4
) (
    input  logic                   clk,
    input  logic                   init,

    // instruction port
    input  logic                   ic_req_valid,
    input  mem_pkg::addr_t         ic_req_addr,
    output logic                   ic_req_ready,
    output logic                   ic_resp_valid,
    output mem_pkg::block_t        ic_resp_data,

    // data port
    input  logic                   dc_req_valid,
    input  mem_pkg::mem_op_t       dc_req_op,
    input  mem_pkg::addr_t         dc_req_addr,
    input  mem_pkg::word_t         dc_req_wdata,
    input  mem_pkg::access_width_t dc_req_width,
    output logic                   dc_req_ready,
    output logic                   dc_resp_valid,
    output mem_pkg::block_t        dc_resp_data
);

    mem_bus_if mem_bus (
        .clk (clk)
    );

    mem_ctrl #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_mem_ctrl (
        .clk           (clk),
        .init          (init),
        .ic_req_valid  (ic_req_valid),
        .ic_req_addr   (ic_req_addr),
        .ic_req_ready  (ic_req_ready),
        .ic_resp_valid (ic_resp_valid),
        .ic_resp_data  (ic_resp_data),
        .dc_req_valid  (dc_req_valid),
        .dc_req_op     (dc_req_op),
        .dc_req_addr   (dc_req_addr),
        .dc_req_wdata  (dc_req_wdata),
        .dc_req_width  (dc_req_width),
        .dc_req_ready  (dc_req_ready),
        .dc_resp_valid (dc_resp_valid),
        .dc_resp_data  (dc_resp_data),
        .bus           (mem_bus.ctrl)
    );

    // latency from handshake to response is N_DELAY_CYCLES+1
    main_mem #(
        .MEM_BLOCKS     (MEM_BLOCKS),
        .N_DELAY_CYCLES (N_DELAY_CYCLES)
    ) u_main_mem (
        .clk  (clk),
        .init (init),
        .bus  (mem_bus.mem)
    );

endmodule

`default_nettype wire

/* logic/mem_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl #(
    parameter int unsigned MAX_OUTSTANDING = 4
) (
    input  logic                   clk,
    input  logic                   init,

    // instruction port, reads only
    input  logic                   ic_req_valid,
    input  mem_pkg::addr_t         ic_req_addr,
    output logic                   ic_req_ready,
    output logic                   ic_resp_valid,
    output mem_pkg::block_t        ic_resp_data,

    // data port
    input  logic                   dc_req_valid,
    input  mem_pkg::mem_op_t       dc_req_op,
    input  mem_pkg::addr_t         dc_req_addr,
    input  mem_pkg::word_t         dc_req_wdata,
    input  mem_pkg::access_width_t dc_req_width,
    output logic                   dc_req_ready,
    output logic                   dc_resp_valid,
    output mem_pkg::block_t        dc_resp_data,

    mem_bus_if.ctrl                bus
);
    import mem_pkg::*;

    localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

    typedef logic [CNT_W-1:0] credit_t;

    credit_t    outstanding;   // reads sent but not yet answered
    cache_sel_t last_grant;
    logic       running;       // low during init, high one edge later
    logic       read_ok;
    logic       ic_elig;
    logic       dc_elig;
    logic       gnt_ic;
    logic       gnt_dc;
    logic       rd_issue;
    logic       rd_done;

    assign read_ok = outstanding < credit_t'(MAX_OUTSTANDING);
    assign ic_elig = running && ic_req_valid && read_ok;
    assign dc_elig = running && dc_req_valid && ((dc_req_op == WRITE) || read_ok);

    // round robin when both can go
    always_comb begin
        gnt_ic = 1'b0;
        gnt_dc = 1'b0;
        if (ic_elig && dc_elig) begin
            if (last_grant == ICACHE) begin
                gnt_dc = 1'b1;
            end else begin
                gnt_ic = 1'b1;
            end
        end else begin
            gnt_ic = ic_elig;
            gnt_dc = dc_elig;
        end
    end

    assign ic_req_ready = gnt_ic;
    assign dc_req_ready = gnt_dc;

    // granted request goes straight onto the bus
    always_comb begin
        bus.req_valid = gnt_ic || gnt_dc;
        if (gnt_dc) begin
            bus.req_cache = DCACHE;
            bus.req_op    = dc_req_op;
            bus.req_addr  = dc_req_addr;
            bus.req_wdata = dc_req_wdata;
            bus.req_width = dc_req_width;
        end else begin
            bus.req_cache = ICACHE;
            bus.req_op    = READ;
            bus.req_addr  = ic_req_addr;
            bus.req_wdata = '0;
            bus.req_width = WORD;
        end
    end

    assign rd_issue = bus.req_valid && (bus.req_op == READ);
    assign rd_done  = bus.resp_valid;

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            running     <= 1'b0;
            last_grant  <= DCACHE;  // icache wins the first tie
            outstanding <= '0;
        end else begin
            running <= 1'b1;
            if (ic_elig && dc_elig) begin
                last_grant <= gnt_dc ? DCACHE : ICACHE;
            end
            // issue and return in the same cycle cancel
            if (rd_issue && !rd_done) begin
                outstanding <= outstanding + 1'b1;
            end else if (rd_done && !rd_issue) begin
                outstanding <= outstanding - 1'b1;
            end
        end
    end

    // response steering by tag
    assign ic_resp_valid = bus.resp_valid && (bus.resp_cache == ICACHE);
    assign dc_resp_valid = bus.resp_valid && (bus.resp_cache == DCACHE);
    assign ic_resp_data  = bus.resp_data;  // zero when idle
    assign dc_resp_data  = bus.resp_data;

endmodule

`default_nettype wire

/* logic/main_mem.sv */
`timescale 1ns/10ps
`default_nettype none

// fixed latency block memory
// request latch, then N_DELAY_CYCLES shift stages, then the access itself
module main_mem #(
    parameter int unsigned MEM_BLOCKS     = 64,
    parameter int unsigned N_DELAY_CYCLES = 5
) (
    input logic    clk,
    input logic    init,
    mem_bus_if.mem bus
);
    import mem_pkg::*;

    localparam int unsigned IDX_W = (MEM_BLOCKS > 1) ? $clog2(MEM_BLOCKS) : 1;

    typedef logic [IDX_W-1:0] blk_idx_t;

    // one in-flight request
    typedef struct packed {
        logic          valid;
        cache_sel_t    cache;
        mem_op_t       op;
        addr_t         addr;
        word_t         wdata;
        access_width_t width;
    } mem_req_t;

    mem_req_t req_pipe [N_DELAY_CYCLES+1];  // entry 0 is the request latch
    mem_req_t last_req;
    block_t   mem [MEM_BLOCKS];
    blk_idx_t last_idx;
    block_t   old_block;
    block_t   merged_block;
    logic     do_read;
    logic     do_write;

    assign last_req  = req_pipe[N_DELAY_CYCLES];
    assign last_idx  = blk_idx_t'((last_req.addr >> OFFSET_W) % MEM_BLOCKS);
    assign old_block = mem[last_idx];
    assign do_read   = last_req.valid && (last_req.op == READ);
    assign do_write  = last_req.valid && (last_req.op == WRITE);

    store_merge u_store_merge (
        .old_block (old_block),
        .wdata     (last_req.wdata),
        .offset    (last_req.addr[OFFSET_W-1:0]),
        .width     (last_req.width),
        .new_block (merged_block)
    );

    // request pipeline and response register
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int i = 0; i <= N_DELAY_CYCLES; i++) begin
                req_pipe[i] <= '0;
            end
            bus.resp_valid <= 1'b0;
            bus.resp_cache <= ICACHE;
            bus.resp_data  <= '0;
        end else begin
            req_pipe[0] <= '{
                valid: bus.req_valid,
                cache: bus.req_cache,
                op:    bus.req_op,
                addr:  bus.req_addr,
                wdata: bus.req_wdata,
                width: bus.req_width
            };
            for (int i = N_DELAY_CYCLES; i > 0; i--) begin
                req_pipe[i] <= req_pipe[i-1];
            end

            // stores are posted, only reads answer
            bus.resp_valid <= do_read;
            bus.resp_cache <= last_req.cache;
            bus.resp_data  <= do_read ? old_block : '0;
        end
    end

    // block array, written by the last stage only
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int i = 0; i < MEM_BLOCKS; i++) begin
                mem[i] <= '0;
            end
        end else if (do_write) begin
            mem[last_idx] <= merged_block;
        end
    end

endmodule

`default_nettype wire

/* logic/store_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module store_merge (
    input  mem_pkg::block_t        old_block,
    input  mem_pkg::word_t         wdata,
    input  mem_pkg::block_offset_t offset,
    input  mem_pkg::access_width_t width,
    output mem_pkg::block_t        new_block
);
    import mem_pkg::*;

    logic [5:0] lane_lsb;  // bit position of the addressed byte

    assign lane_lsb = {offset, 3'b000};

    always_comb begin
        new_block = old_block;  // untouched bytes keep their value
        case (width)
            BYTE: begin
                new_block[lane_lsb +: 8] = wdata[7:0];
            end
            HALF: begin
                new_block[lane_lsb +: 16] = wdata[15:0];
            end
            WORD: begin
                new_block[lane_lsb +: 32] = wdata[31:0];
            end
            default: begin
                new_block = old_block;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/mem_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

// request and response bus between the controller and main memory
// main memory takes one request every cycle, so there is no ready
interface mem_bus_if (
    input logic clk
);
    import mem_pkg::*;

    // request side, counts when req_valid is high at a rising edge
    logic          req_valid;
    cache_sel_t    req_cache;
    mem_op_t       req_op;
    addr_t         req_addr;
    word_t         req_wdata;
    access_width_t req_width;

    // response side, one pulse per read
    logic          resp_valid;
    cache_sel_t    resp_cache;
    block_t        resp_data;

    modport ctrl (
        input  clk,
        output req_valid, req_cache, req_op, req_addr, req_wdata, req_width,
        input  resp_valid, resp_cache, resp_data
    );

    modport mem (
        input  clk,
        input  req_valid, req_cache, req_op, req_addr, req_wdata, req_width,
        output resp_valid, resp_cache, resp_data
    );

endinterface

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // address and data widths
    localparam int unsigned ADDR_W   = 32;
    localparam int unsigned WORD_W   = 32;
    localparam int unsigned BLOCK_W  = 64;
    localparam int unsigned OFFSET_W = 3;   // 8 bytes per block

    typedef logic [ADDR_W-1:0]   addr_t;         // byte address
    typedef logic [WORD_W-1:0]   word_t;         // store data from the data port
    typedef logic [BLOCK_W-1:0]  block_t;        // one memory block
    typedef logic [OFFSET_W-1:0] block_offset_t; // byte offset inside a block

    // which client a request or response belongs to
    typedef enum logic {
        ICACHE = 1'b0,
        DCACHE = 1'b1
    } cache_sel_t;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } mem_op_t;

    // store width, only meaningful for data port stores
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } access_width_t;

endpackage

`default_nettype wire
